// ==== include/rvExec_cfg.svh ====
`ifndef RVEXEC_CFG_SVH
`define RVEXEC_CFG_SVH

// Fixed by RV32I
`define XLEN_W    32   // Data path width
`define REG_COUNT 32   // Integer registers x0..x31
`define REG_SEL_W 5    // Register select bits

`endif

// ==== rtl/rvExecPkg.sv ====
package rvExecPkg;

    // --------------------------------------------------
    // Major opcodes handled by the unit
    // --------------------------------------------------
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,   // Register-register ALU
        OPC_OP_IMM = 7'b0010011,   // Register-immediate ALU
        OPC_LUI    = 7'b0110111    // Load upper immediate
    } opcodeE;

    // ALU functions
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,     // Signed compare
        ALU_SLTU,    // Unsigned compare
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB    // Operand B straight out, used by LUI
    } aluOpE;

    // Handshake sequencer
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_EXEC,
        SEQ_WRITE,
        SEQ_ACK
    } seqStateE;

endpackage

// ==== rtl/decodeIf.sv ====
`timescale 1ns/100ps
`include "rvExec_cfg.svh"

interface decodeIf;

    logic [`REG_SEL_W-1:0] rd;
    logic [`REG_SEL_W-1:0] rs1;
    logic [`REG_SEL_W-1:0] rs2;
    logic [`XLEN_W-1:0]    imm;      // Sign-extended, or upper for LUI
    rvExecPkg::aluOpE      aluOp;
    logic                  useImm;   // Operand B from imm
    logic                  illegal;

    // Decoder side
    modport dec (output rd, rs1, rs2, imm, aluOp, useImm, illegal);

    // Sequencer only needs destination and legality
    modport seq (input rd, illegal);

    // Operand routing and ALU control
    modport dp (input rs1, rs2, imm, useImm, aluOp);

endinterface

// ==== rtl/rvDecoder.sv ====
`timescale 1ns/100ps
`include "rvExec_cfg.svh"

module rvDecoder (
    input  logic [`XLEN_W-1:0] instr_i,   // Held stable by the agent
    decodeIf.dec               dec
);

    rvExecPkg::opcodeE opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = rvExecPkg::opcodeE'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        // Field split is the same for every format
        dec.rd      = instr_i[11:7];
        dec.rs1     = instr_i[19:15];
        dec.rs2     = instr_i[24:20];
        dec.imm     = {{20{instr_i[31]}}, instr_i[31:20]};   // I-immediate
        dec.aluOp   = rvExecPkg::ALU_ADD;
        dec.useImm  = 1'b0;
        dec.illegal = 1'b0;

        case (opcode)
            rvExecPkg::OPC_OP: begin
                case (funct3)
                    3'b000: dec.aluOp = funct7[5] ? rvExecPkg::ALU_SUB : rvExecPkg::ALU_ADD;
                    3'b001: dec.aluOp = rvExecPkg::ALU_SLL;
                    3'b010: dec.aluOp = rvExecPkg::ALU_SLT;
                    3'b011: dec.aluOp = rvExecPkg::ALU_SLTU;
                    3'b100: dec.aluOp = rvExecPkg::ALU_XOR;
                    3'b101: dec.aluOp = funct7[5] ? rvExecPkg::ALU_SRA : rvExecPkg::ALU_SRL;
                    3'b110: dec.aluOp = rvExecPkg::ALU_OR;
                    default: dec.aluOp = rvExecPkg::ALU_AND;
                endcase
                // Alternate funct7 only exists for SUB and SRA
                if (funct7 == 7'b0100000)
                    dec.illegal = !(funct3 == 3'b000 || funct3 == 3'b101);
                else if (funct7 != 7'b0000000)
                    dec.illegal = 1'b1;
            end
            rvExecPkg::OPC_OP_IMM: begin
                dec.useImm = 1'b1;
                case (funct3)
                    3'b000: dec.aluOp = rvExecPkg::ALU_ADD;
                    3'b010: dec.aluOp = rvExecPkg::ALU_SLT;
                    3'b011: dec.aluOp = rvExecPkg::ALU_SLTU;
                    3'b100: dec.aluOp = rvExecPkg::ALU_XOR;
                    3'b110: dec.aluOp = rvExecPkg::ALU_OR;
                    3'b111: dec.aluOp = rvExecPkg::ALU_AND;
                    3'b001: begin
                        dec.aluOp   = rvExecPkg::ALU_SLL;
                        dec.illegal = (funct7 != 7'b0000000);
                    end
                    default: begin   // SRLI / SRAI
                        dec.aluOp   = funct7[5] ? rvExecPkg::ALU_SRA : rvExecPkg::ALU_SRL;
                        dec.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    end
                endcase
            end
            rvExecPkg::OPC_LUI: begin
                dec.imm    = {instr_i[31:12], 12'b0};   // U-immediate
                dec.aluOp  = rvExecPkg::ALU_PASSB;
                dec.useImm = 1'b1;
            end
            default: dec.illegal = 1'b1;   // Loads, stores, branches ...
        endcase
    end

endmodule

// ==== rtl/aluUnit.sv ====
`timescale 1ns/100ps
`include "rvExec_cfg.svh"

module aluUnit (
    decodeIf.dp                dp,
    input  logic [`XLEN_W-1:0] srcA_i,        // rs1 data
    input  logic [`XLEN_W-1:0] srcB_i,        // rs2 data
    output logic [`XLEN_W-1:0] aluResult_o
);

    logic [`XLEN_W-1:0] opB;
    logic [4:0]         shamt;

    // Operand B select
    assign opB   = dp.useImm ? dp.imm : srcB_i;
    assign shamt = opB[4:0];   // Shifts only look at the low five bits

    always_comb begin
        case (dp.aluOp)
            rvExecPkg::ALU_ADD:   aluResult_o = srcA_i + opB;
            rvExecPkg::ALU_SUB:   aluResult_o = srcA_i - opB;
            rvExecPkg::ALU_SLL:   aluResult_o = srcA_i << shamt;
            rvExecPkg::ALU_SLT:
                aluResult_o = {{(`XLEN_W-1){1'b0}}, $signed(srcA_i) < $signed(opB)};
            rvExecPkg::ALU_SLTU:
                aluResult_o = {{(`XLEN_W-1){1'b0}}, srcA_i < opB};
            rvExecPkg::ALU_XOR:   aluResult_o = srcA_i ^ opB;
            rvExecPkg::ALU_SRL:   aluResult_o = srcA_i >> shamt;
            rvExecPkg::ALU_SRA:   aluResult_o = $unsigned($signed(srcA_i) >>> shamt);
            rvExecPkg::ALU_OR:    aluResult_o = srcA_i | opB;
            rvExecPkg::ALU_AND:   aluResult_o = srcA_i & opB;
            rvExecPkg::ALU_PASSB: aluResult_o = opB;
            default:              aluResult_o = '0;
        endcase
    end

endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/100ps
`include "rvExec_cfg.svh"

// --------------------------------------------------
// Integer register bank, two reads and one write
// --------------------------------------------------
module registerFile (
    input  logic                  clk_i,
    input  logic                  regWeN_i,    // Write strobe, active low
    input  logic [`XLEN_W-1:0]    data_i,
    input  logic [`REG_SEL_W-1:0] regDst_i,
    input  logic [`REG_SEL_W-1:0] regSrcA_i,
    input  logic [`REG_SEL_W-1:0] regSrcB_i,
    output logic [`XLEN_W-1:0]    srcA_o,
    output logic [`XLEN_W-1:0]    srcB_o
);

    logic [`XLEN_W-1:0] bank [0:`REG_COUNT-1];

    // Falling edge write, lands mid-cycle of SEQ_WRITE
    always_ff @(negedge clk_i) begin
        if (!regWeN_i && regDst_i != '0) begin   // x0 never written
            bank[regDst_i] <= data_i;
        end
    end

    // x0 reads as zero regardless of bank contents
    assign srcA_o = (regSrcA_i == '0) ? '0 : bank[regSrcA_i];
    assign srcB_o = (regSrcB_i == '0) ? '0 : bank[regSrcB_i];

endmodule

// ==== rtl/execSequencer.sv ====
`timescale 1ns/100ps
`include "rvExec_cfg.svh"

module execSequencer (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               instrReq_i,
    decodeIf.seq               seq,
    input  logic [`XLEN_W-1:0] aluResult_i,
    output logic               regWeN_o,      // Active low
    output logic [`XLEN_W-1:0] regWrData_o,
    output logic               instrAck_o,
    output logic [`XLEN_W-1:0] result_o,
    output logic               illegal_o
);

    rvExecPkg::seqStateE stateQ;
    rvExecPkg::seqStateE stateD;
    logic [`XLEN_W-1:0]  resultQ;
    logic                illegalQ;

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        stateD = stateQ;
        case (stateQ)
            rvExecPkg::SEQ_IDLE: begin
                if (instrReq_i)
                    stateD = rvExecPkg::SEQ_EXEC;
            end
            rvExecPkg::SEQ_EXEC:  stateD = rvExecPkg::SEQ_WRITE;
            rvExecPkg::SEQ_WRITE: stateD = rvExecPkg::SEQ_ACK;
            rvExecPkg::SEQ_ACK: begin
                // Hold until the agent lets go
                if (!instrReq_i)
                    stateD = rvExecPkg::SEQ_IDLE;
            end
            default: stateD = rvExecPkg::SEQ_IDLE;
        endcase
    end

    // --------------------------------------------------
    // State and result capture
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stateQ   <= rvExecPkg::SEQ_IDLE;
            resultQ  <= '0;
            illegalQ <= 1'b0;
        end else begin
            stateQ <= stateD;
            if (stateQ == rvExecPkg::SEQ_EXEC) begin
                resultQ  <= seq.illegal ? '0 : aluResult_i;   // Nothing reported for illegal
                illegalQ <= seq.illegal;
            end
        end
    end

    // One low cycle, register file samples it on the falling edge
    assign regWeN_o = !((stateQ == rvExecPkg::SEQ_WRITE) && !illegalQ);

    assign regWrData_o = resultQ;
    assign instrAck_o  = (stateQ == rvExecPkg::SEQ_ACK);
    assign result_o    = resultQ;
    assign illegal_o   = illegalQ;

endmodule

// ==== rtl/rvExecCore.sv ====
`timescale 1ns/100ps
`include "rvExec_cfg.svh"

module rvExecCore (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               instrReq_i,
    input  logic [`XLEN_W-1:0] instr_i,
    output logic               instrAck_o,
    output logic [`XLEN_W-1:0] result_o,
    output logic               illegal_o
);

    logic [`XLEN_W-1:0] srcA;        // rs1 read data
    logic [`XLEN_W-1:0] srcB;        // rs2 read data
    logic [`XLEN_W-1:0] aluResult;
    logic [`XLEN_W-1:0] regWrData;
    logic               regWeN;

    decodeIf decBus ();

    // --------------------------------------------------
    // Decode and datapath
    // --------------------------------------------------
    rvDecoder u_decoder (
        .instr_i (instr_i),
        .dec     (decBus.dec)
    );

    registerFile u_regFile (
        .clk_i     (clk_i),
        .regWeN_i  (regWeN),
        .data_i    (regWrData),
        .regDst_i  (decBus.rd),
        .regSrcA_i (decBus.rs1),
        .regSrcB_i (decBus.rs2),
        .srcA_o    (srcA),
        .srcB_o    (srcB)
    );

    aluUnit u_alu (
        .dp          (decBus.dp),
        .srcA_i      (srcA),
        .srcB_i      (srcB),
        .aluResult_o (aluResult)
    );

    // Handshake control
    execSequencer u_seq (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .instrReq_i  (instrReq_i),
        .seq         (decBus.seq),
        .aluResult_i (aluResult),
        .regWeN_o    (regWeN),
        .regWrData_o (regWrData),
        .instrAck_o  (instrAck_o),
        .result_o    (result_o),
        .illegal_o   (illegal_o)
    );

endmodule

// ==== tests/rvExecCore_assert.sv ====
`timescale 1ns/100ps
`include "rvExec_cfg.svh"

module rvExecCore_assert (
    input logic               clk_i,
    input logic               rst_i,
    input logic               instrReq_i,
    input logic               instrAck_i,
    input logic               regWeN_i,     // Active low
    input logic [`XLEN_W-1:0] result_i
);

    // --------------------------------------------------
    // Handshake and write strobe rules
    // --------------------------------------------------
    ackNeedsReq: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(instrAck_i) |-> $past(instrReq_i))
        else $error("acknowledge rose without a pending request");

    // Register write only between request and acknowledge
    weDuringRequest: assert property (@(posedge clk_i) disable iff (rst_i)
        !regWeN_i |-> instrReq_i && !instrAck_i)
        else $error("register write enable low outside a pending request");

    // Result frozen for the whole acknowledge phase
    resultHeld: assert property (@(posedge clk_i) disable iff (rst_i)
        instrAck_i && $past(instrAck_i) |-> $stable(result_i))
        else $error("result changed while acknowledge was high");

endmodule

bind execSequencer rvExecCore_assert u_assert (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .instrReq_i (instrReq_i),
    .instrAck_i (instrAck_o),
    .regWeN_i   (regWeN_o),
    .result_i   (result_o)
);

// ==== tests/rvExecCore_tb.sv ====
`timescale 1ns/100ps

module rvExecCore_tb;

    localparam int clkPeriod    = 100;
    localparam int resetCycles  = 10;
    localparam int maxInstr     = 60;   // About 55 issued by the tests
    localparam int instrCycles  = 16;   // Handshake plus longest hold
    localparam int marginCycles = 50;

    logic        clk;
    logic        rst;
    logic        instrReq;
    logic [31:0] instr;
    logic        instrAck;
    logic [31:0] result;
    logic        illegal;

    logic [31:0] refRegs [0:31];   // Reference register state
    logic [31:0] lfsrQ;
    int          errCount;
    int          instrCount;

    rvExecCore u_dut (
        .clk_i      (clk),
        .rst_i      (rst),
        .instrReq_i (instrReq),
        .instr_i    (instr),
        .instrAck_o (instrAck),
        .result_o   (result),
        .illegal_o  (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsrQ = {lfsrQ[30:0], lfsrQ[31] ^ lfsrQ[21] ^ lfsrQ[1] ^ lfsrQ[0]};
            bits  = {bits[30:0], lfsrQ[0]};
        end
        return bits;
    endfunction

    // --------------------------------------------------
    // Instruction encoding
    // --------------------------------------------------
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // RV32I result rules, zero for anything illegal
    function automatic logic [31:0] modelExec(input logic [31:0] ins, output logic bad);
        logic [31:0] a;
        logic [31:0] b;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic        alt;
        a   = refRegs[ins[19:15]];
        b   = refRegs[ins[24:20]];
        f7  = ins[31:25];
        f3  = ins[14:12];
        alt = f7[5];
        bad = 1'b0;
        if (ins[6:0] == 7'b0110111)
            return {ins[31:12], 12'h000};
        if (ins[6:0] == 7'b0010011) begin
            b   = {{20{ins[31]}}, ins[31:20]};
            alt = (f3 == 3'b101) && f7[5];   // Only SRAI has an alternate form
            if (f3 == 3'b001)
                bad = f7 != 7'd0;
            else if (f3 == 3'b101)
                bad = (f7 & 7'b1011111) != 7'd0;
        end else if (ins[6:0] == 7'b0110011) begin
            bad = ((f7 & 7'b1011111) != 7'd0) || (alt && f3 != 3'b000 && f3 != 3'b101);
        end else begin
            bad = 1'b1;
        end
        if (bad)
            return 32'h0;
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Full four-phase transfer, request held for hold extra cycles after the ack
    task automatic issueInstr(input string name, input logic [31:0] ins, input int hold);
        logic [31:0] expVal;
        logic        expBad;
        int          cycles;
        expVal = modelExec(ins, expBad);
        cycles = 0;
        instrCount++;
        @(negedge clk);
        instr    = ins;
        instrReq = 1'b1;
        do begin
            @(negedge clk);
            cycles++;
        end while (!instrAck && cycles < 20);
        if (!instrAck) begin
            $display("Error %s: no acknowledge within 20 cycles", name);
            errCount++;
        end else if (cycles != 3) begin
            $display("Fail %s ack latency expected 3 actual %0d", name, cycles);
            errCount++;
        end
        if (result !== expVal) begin
            $display("Fail %s result expected %h actual %h", name, expVal, result);
            errCount++;
        end
        if (illegal !== expBad) begin
            $display("Fail %s illegal expected %b actual %b", name, expBad, illegal);
            errCount++;
        end
        repeat (hold) begin
            @(negedge clk);
            if (!instrAck) begin
                $display("Error %s: acknowledge fell while request high", name);
                errCount++;
            end
            if (result !== expVal) begin
                $display("Fail %s held result expected %h actual %h", name, expVal, result);
                errCount++;
            end
        end
        instrReq = 1'b0;
        @(negedge clk);
        if (instrAck) begin
            $display("Error %s: acknowledge still high one cycle after request dropped", name);
            errCount++;
        end
        if (!expBad && ins[11:7] != 5'd0)
            refRegs[ins[11:7]] = expVal;
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic resetTest();
        if (instrAck !== 1'b0) begin
            $display("Fail reset ack expected %b actual %b", 1'b0, instrAck);
            errCount++;
        end
        if (illegal !== 1'b0) begin
            $display("Fail reset illegal expected %b actual %b", 1'b0, illegal);
            errCount++;
        end
        if (result !== 32'h0) begin
            $display("Fail reset result expected %h actual %h", 32'h0, result);
            errCount++;
        end
    endtask

    task automatic immediateTest();
        logic [2:0]  f3List [9] = '{3'b000, 3'b100, 3'b110, 3'b111, 3'b010,
                                    3'b011, 3'b001, 3'b101, 3'b101};
        logic [31:0] rnd;
        logic [11:0] imm;
        rnd     = lfsrBits(20);
        rnd[19] = 1'b1;   // Negative x1 so SRAI differs from SRLI
        issueInstr("lui", encU(rnd[19:0], 5'd1), 0);
        for (int k = 0; k < 9; k++) begin
            rnd = lfsrBits(12);
            imm = rnd[11:0];
            if (f3List[k] == 3'b001 || f3List[k] == 3'b101)
                imm = {(k == 8) ? 7'b0100000 : 7'b0000000, imm[4:0]};
            issueInstr($sformatf("op-imm f3=%0d", f3List[k]),
                       encI(imm, f3List[k], 5'(k + 2), 5'd1), 0);
        end
        for (int r = 1; r <= 10; r++)   // Read back through ADD with x0
            issueInstr($sformatf("readback x%0d", r), encR(7'd0, 3'b000, 5'd31, 5'(r), 5'd0), 0);
    endtask

    task automatic registerOpsTest();
        logic [3:0]  ops [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
        logic [31:0] rnd;
        for (int r = 12; r < 14; r++) begin
            rnd        = lfsrBits(32);
            rnd[31:30] = (r == 12) ? 2'b11 : 2'b00;   // x12 negative, x13 positive
            issueInstr("lui fill", encU(rnd[31:12], 5'(r)), 0);
            issueInstr("addi fill", encI(rnd[11:0], 3'b000, 5'(r), 5'(r)), 0);
        end
        for (int k = 0; k < 10; k++) begin
            issueInstr($sformatf("r-type %h", ops[k]),
                       encR({1'b0, ops[k][3], 5'b0}, ops[k][2:0], 5'(16 + k), 5'd12, 5'd13), 0);
            issueInstr($sformatf("r-type swap %h", ops[k]),
                       encR({1'b0, ops[k][3], 5'b0}, ops[k][2:0], 5'(16 + k), 5'd13, 5'd12), 0);
        end
    endtask

    task automatic zeroRegTest();
        logic [31:0] rnd;
        rnd = lfsrBits(12);
        issueInstr("x0 write", encI(rnd[11:0], 3'b000, 5'd0, 5'd1), 0);
        issueInstr("x0 read", encR(7'd0, 3'b000, 5'd20, 5'd0, 5'd0), 0);
        issueInstr("x0 plus x1", encR(7'd0, 3'b000, 5'd20, 5'd1, 5'd0), 0);
    endtask

    // x4 holds ORI of a negative x1 and x6 holds SLTI of it, so neither is zero
    task automatic illegalTest();
        issueInstr("store", {7'h00, 5'd1, 5'd2, 3'b010, 5'd4, 7'b0100011}, 0);
        issueInstr("bad funct7", encR(7'b0000001, 3'b000, 5'd6, 5'd1, 5'd2), 0);
        issueInstr("x4 reread", encR(7'd0, 3'b000, 5'd21, 5'd4, 5'd0), 0);
        issueInstr("x6 reread", encR(7'd0, 3'b000, 5'd22, 5'd6, 5'd0), 0);
    endtask

    task automatic handshakeTest();
        logic [31:0] rnd;
        for (int k = 0; k < 4; k++) begin
            rnd = lfsrBits(3);
            issueInstr("slow agent", encI(12'h123, 3'b000, 5'd23, 5'(2 + k)), int'(rnd[2:0]) + 1);
        end
    endtask

    // Watchdog
    initial begin
        #((maxInstr * instrCycles + resetCycles + marginCycles) * clkPeriod);
        $display("Timeout: tests did not finish, %0d errors so far", errCount);
        $display("test failed");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        instrReq   = 1'b0;
        instr      = '0;
        lfsrQ      = 32'h9739_3b9e;
        errCount   = 0;
        instrCount = 0;
        refRegs[0] = '0;   // x0, never updated
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        resetTest();
        immediateTest();
        registerOpsTest();
        zeroRegTest();
        illegalTest();
        handshakeTest();
        $display("Instructions %0d, errors %0d", instrCount, errCount);
        if (errCount == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== rvExecCore.f ====
+incdir+include
rtl/rvExecPkg.sv
rtl/decodeIf.sv
rtl/rvDecoder.sv
rtl/aluUnit.sv
rtl/registerFile.sv
rtl/execSequencer.sv
rtl/rvExecCore.sv
tests/rvExecCore_assert.sv
tests/rvExecCore_tb.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module rvExecCore_tb -f rvExecCore.f -Mdir obj_dir

run: compile
	./obj_dir/VrvExecCore_tb > sim.log 2>&1; cat sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
